// File: verification/program_input.txt
# I <imem address> <instruction>, hex, loaded over req/ack in this order
# W <register> <value>, hex, expected writebacks in program order
I 00 6045  # addi r1, r0, 5
I 01 6083  # addi r2, r0, 3
I 02 1298  # add  r3, r1, r2
I 03 2460  # sub  r4, r2, r1
I 04 5868  # slt  r5, r4, r1
I 05 38f0  # and  r6, r4, r3
I 06 4280  # or   r0, r1, r2
I 07 1078  # add  r7, r0, r1
I 08 82c2  # sw   r3, 2(r1)
I 09 7087  # lw   r2, 7(r0)
I 0a 1488  # add  r1, r2, r2
I 0b 9294  # beq  r1, r2, 0x14 not taken
I 0c a290  # bne  r1, r2, 0x10 taken
I 0d 60ff  # addi r3, r0, 63 squashed
I 0e 613e  # addi r4, r0, 62 squashed
I 10 9594  # beq  r2, r6, 0x14 taken
I 11 617d  # addi r5, r0, 61 squashed
I 12 61bc  # addi r6, r0, 60 squashed
I 14 b018  # jmp  0x18
I 15 61fc  # addi r7, r0, 60 skipped
I 18 6b49  # addi r5, r5, 9
I 19 c000  # halt
W 1 0005
W 2 0003
W 3 0008
W 4 fffe
W 5 0001
W 6 0008
W 0 0007
W 7 0005
W 2 0008
W 1 0010
W 5 000a

// File: src.f
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/control_unit.sv
hw/register_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/processor.sv
verification/processor_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
verilator --binary --timing --assert --top-module processor_tb -f src.f -o processor_sim \
  || exit 1
./obj_dir/processor_sim > sim.log 2>&1
cat sim.log
grep -qF '** FAIL **' sim.log && exit 1
grep -qF '** PASS **' sim.log || exit 1
exit 0

// File: verification/processor_tb.sv
`default_nettype none

module processor_tb;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               run;
  logic               load_req;
  cpu_pkg::pc_t       load_addr;
  cpu_pkg::inst_t     load_data;
  logic               load_ack;
  logic               wb_valid;
  cpu_pkg::reg_addr_t wb_reg;
  cpu_pkg::data_t     wb_data;
  logic               halted;

  // program image and expected writebacks
  cpu_pkg::pc_t       prog_addr [$];
  cpu_pkg::inst_t     prog_inst [$];
  cpu_pkg::reg_addr_t exp_reg [$];
  cpu_pkg::data_t     exp_data [$];

  int                 wb_count = 0;
  int                 cycle_count = 0;
  int                 cycle_limit = 1000;
  // outputs as seen on the previous falling edge
  logic               ack_prev = 1'b0;
  logic               req_prev = 1'b0;
  logic               halted_prev = 1'b0;

  processor #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) processor_inst (
    .clk, .rst_n, .run, .load_req, .load_addr, .load_data,
    .load_ack, .wb_valid, .wb_reg, .wb_data, .halted
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_reg(input cpu_pkg::reg_addr_t got, input cpu_pkg::reg_addr_t exp,
                           input string what);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s, got r%0d, expected r%0d", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_data(input cpu_pkg::data_t got, input cpu_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s, got %b, expected %b", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic read_program();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [31:0]      field_1;
    logic [31:0]      field_2;
    logic [8*256-1:0] rest;
    fd = $fopen("verification/program_input.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/program_input.txt");
      $display("** FAIL **");
      $fatal(1, "missing data file");
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", tag);
      if (code == 1) begin
        if (tag == "#") begin
          // rest of the line is a comment
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h", field_1, field_2);
          if (code == 2 && tag == "I") begin
            prog_addr.push_back(field_1[5:0]);
            prog_inst.push_back(field_2[15:0]);
          end else if (code == 2 && tag == "W") begin
            exp_reg.push_back(field_1[2:0]);
            exp_data.push_back(field_2[15:0]);
          end else begin
            $display("the data file holds a record that cannot be read");
            $display("** FAIL **");
            $fatal(1, "bad record");
          end
        end
      end
    end
    $fclose(fd);
  endtask

  // four-phase write of one instruction word
  task automatic load_word(input cpu_pkg::pc_t addr, input cpu_pkg::inst_t inst);
    load_addr = addr;
    load_data = inst;
    load_req  = 1'b1;
    do begin
      next_cycle();
    end while (load_ack !== 1'b1);
    load_req = 1'b0;
    do begin
      next_cycle();
    end while (load_ack !== 1'b0);
  endtask

  ////////////////////////////////////////
  // monitors
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout, the program never halted within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (!ack_prev && load_ack) begin
        check_flag(req_prev, 1'b1, "load_ack rose without load_req");
      end
      if (ack_prev && !load_ack) begin
        check_flag(req_prev, 1'b0, "load_ack fell while load_req high");
      end
      if (wb_valid) begin
        check_flag(halted, 1'b0, "writeback after halted");
        check_flag(wb_count < exp_reg.size(), 1'b1, "more writebacks than expected");
        check_reg(wb_reg, exp_reg[wb_count], $sformatf("writeback %0d register", wb_count));
        check_data(wb_data, exp_data[wb_count], $sformatf("writeback %0d value", wb_count));
        wb_count = wb_count + 1;
      end
      if (halted && !halted_prev) begin
        check_flag(wb_count == exp_reg.size(), 1'b1, "halted before every writeback");
      end
    end
    ack_prev    = load_ack;
    req_prev    = load_req;
    halted_prev = halted;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    run       = 1'b0;
    load_req  = 1'b0;
    load_addr = '0;
    load_data = '0;
    read_program();
    cycle_limit = 16 + 6 * prog_addr.size() + 12 * prog_addr.size() + 50;
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    check_flag(load_ack, 1'b0, "load_ack after reset");
    check_flag(wb_valid, 1'b0, "wb_valid after reset");
    check_flag(halted, 1'b0, "halted after reset");
    foreach (prog_addr[i]) begin
      load_word(prog_addr[i], prog_inst[i]);
    end
    run = 1'b1;
    while (halted !== 1'b1) begin
      next_cycle();
    end
    // any stray writeback would land within a few cycles
    repeat (8) next_cycle();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/processor.sv
`default_nettype none

module processor #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 run,
  input  wire                 load_req,
  input  wire cpu_pkg::pc_t   load_addr,
  input  wire cpu_pkg::inst_t load_data,
  output logic                load_ack,
  output logic                wb_valid,
  output cpu_pkg::reg_addr_t  wb_reg,
  output cpu_pkg::data_t      wb_data,
  output logic                halted
);

  // fetch and decode
  cpu_pkg::inst_t     if_id_inst;
  cpu_pkg::data_t     rdata_1, rdata_2;
  cpu_pkg::alu_op_t   alu_op;
  logic               alu_src, reg_dst, reg_write, mem_read, mem_write;
  logic               is_beq, is_bne, is_halt;
  cpu_pkg::fwd_sel_t  fwd_a, fwd_b;
  logic               stall, flush;

  // execute
  cpu_pkg::reg_addr_t id_ex_rt;
  logic               id_ex_is_load, branch_taken;
  cpu_pkg::pc_t       branch_target;
  cpu_pkg::data_t     ex_mem_alu_result, ex_mem_store_data;
  cpu_pkg::reg_addr_t ex_mem_dst;
  logic               ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_halt;

  // writeback
  cpu_pkg::reg_addr_t mem_wb_dst;
  logic               mem_wb_reg_write;
  cpu_pkg::data_t     mem_wb_data;

  assign wb_valid = mem_wb_reg_write;
  assign wb_reg   = mem_wb_dst;
  assign wb_data  = mem_wb_data;

  fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_inst (
    .clk, .rst_n, .run, .load_req, .load_addr, .load_data,
    .stall, .flush, .branch_target, .load_ack, .if_id_inst
  );

  control_unit control_inst (
    .clk, .rst_n, .if_id_inst, .id_ex_rt, .id_ex_is_load,
    .ex_mem_dst, .ex_mem_reg_write, .mem_wb_dst, .mem_wb_reg_write, .branch_taken,
    .alu_op, .alu_src, .reg_dst, .reg_write, .mem_read, .mem_write,
    .is_beq, .is_bne, .is_halt, .fwd_a, .fwd_b, .stall, .flush
  );

  register_file regfile_inst (
    .clk, .rst_n, .we(mem_wb_reg_write), .waddr(mem_wb_dst), .wdata(mem_wb_data),
    .raddr_1(if_id_inst[11:9]), .raddr_2(if_id_inst[8:6]), .rdata_1, .rdata_2
  );

  execute_stage execute_inst (
    .clk, .rst_n, .stall, .flush, .if_id_inst, .rdata_1, .rdata_2,
    .alu_op, .alu_src, .reg_dst, .reg_write, .mem_read, .mem_write,
    .is_beq, .is_bne, .is_halt, .fwd_a, .fwd_b, .mem_wb_data,
    .id_ex_rt, .id_ex_is_load, .branch_taken, .branch_target,
    .ex_mem_alu_result, .ex_mem_store_data, .ex_mem_dst, .ex_mem_reg_write,
    .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_halt
  );

  memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) memory_inst (
    .clk, .rst_n, .ex_mem_alu_result, .ex_mem_store_data, .ex_mem_dst,
    .ex_mem_reg_write, .ex_mem_mem_read, .ex_mem_mem_write, .ex_mem_halt,
    .mem_wb_dst, .mem_wb_reg_write, .mem_wb_data, .halted
  );

endmodule

`default_nettype wire

// File: hw/memory_stage.sv
`default_nettype none

module memory_stage #(
  parameter int DMEM_DEPTH = 64
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire cpu_pkg::data_t     ex_mem_alu_result,
  input  wire cpu_pkg::data_t     ex_mem_store_data,
  input  wire cpu_pkg::reg_addr_t ex_mem_dst,
  input  wire                     ex_mem_reg_write,
  input  wire                     ex_mem_mem_read,
  input  wire                     ex_mem_mem_write,
  input  wire                     ex_mem_halt,
  output cpu_pkg::reg_addr_t      mem_wb_dst,
  output logic                    mem_wb_reg_write,
  output cpu_pkg::data_t          mem_wb_data,
  output logic                    halted
);

  cpu_pkg::data_t dmem [DMEM_DEPTH];
  cpu_pkg::pc_t   addr;
  cpu_pkg::data_t load_value;

  // word address is the low alu bits
  assign addr       = ex_mem_alu_result[5:0];
  assign load_value = dmem[addr];

  always_ff @(posedge clk) begin
    if (ex_mem_mem_write) begin
      dmem[addr] <= ex_mem_store_data;
    end
  end

  ////////////////////////////////////////
  // mem/wb
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb_reg_write <= 1'b0;
      halted           <= 1'b0;
    end else begin
      mem_wb_reg_write <= ex_mem_reg_write;
      // sticky until reset
      if (ex_mem_halt) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    mem_wb_dst  <= ex_mem_dst;
    mem_wb_data <= ex_mem_mem_read ? load_value : ex_mem_alu_result;
  end

  a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_mem_mem_read || ex_mem_mem_write) |-> (ex_mem_alu_result < DMEM_DEPTH));

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none

module execute_stage (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     stall,
  input  wire                     flush,
  input  wire cpu_pkg::inst_t     if_id_inst,
  input  wire cpu_pkg::data_t     rdata_1,
  input  wire cpu_pkg::data_t     rdata_2,
  input  wire cpu_pkg::alu_op_t   alu_op,
  input  wire                     alu_src,
  input  wire                     reg_dst,
  input  wire                     reg_write,
  input  wire                     mem_read,
  input  wire                     mem_write,
  input  wire                     is_beq,
  input  wire                     is_bne,
  input  wire                     is_halt,
  input  wire cpu_pkg::fwd_sel_t  fwd_a,
  input  wire cpu_pkg::fwd_sel_t  fwd_b,
  input  wire cpu_pkg::data_t     mem_wb_data,
  output cpu_pkg::reg_addr_t      id_ex_rt,
  output logic                    id_ex_is_load,
  output logic                    branch_taken,
  output cpu_pkg::pc_t            branch_target,
  output cpu_pkg::data_t          ex_mem_alu_result,
  output cpu_pkg::data_t          ex_mem_store_data,
  output cpu_pkg::reg_addr_t      ex_mem_dst,
  output logic                    ex_mem_reg_write,
  output logic                    ex_mem_mem_read,
  output logic                    ex_mem_mem_write,
  output logic                    ex_mem_halt
);

  cpu_pkg::alu_op_t   id_ex_alu_op;
  logic               id_ex_alu_src, id_ex_reg_dst, id_ex_reg_write, id_ex_mem_write;
  logic               id_ex_beq, id_ex_bne, id_ex_halt;
  cpu_pkg::reg_addr_t id_ex_rd;
  cpu_pkg::data_t     id_ex_data_1, id_ex_data_2;
  // imm or absolute address
  cpu_pkg::pc_t       id_ex_field;
  cpu_pkg::data_t     op_a, fwd_val_b, op_b, alu_result;
  cpu_pkg::reg_addr_t dst;

  ////////////////////////////////////////
  // id/ex
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || stall || flush) begin
      {id_ex_alu_src, id_ex_reg_dst, id_ex_reg_write} <= '0;
      {id_ex_is_load, id_ex_mem_write, id_ex_beq, id_ex_bne, id_ex_halt} <= '0;
      id_ex_alu_op <= cpu_pkg::ALU_ADD;
      id_ex_rt     <= '0;
    end else begin
      {id_ex_alu_src, id_ex_reg_dst, id_ex_reg_write} <= {alu_src, reg_dst, reg_write};
      {id_ex_is_load, id_ex_mem_write} <= {mem_read, mem_write};
      {id_ex_beq, id_ex_bne, id_ex_halt} <= {is_beq, is_bne, is_halt};
      id_ex_alu_op <= alu_op;
      id_ex_rt     <= if_id_inst[8:6];
    end
  end

  always_ff @(posedge clk) begin
    id_ex_rd     <= if_id_inst[5:3];
    id_ex_field  <= if_id_inst[5:0];
    id_ex_data_1 <= rdata_1;
    id_ex_data_2 <= rdata_2;
  end

  ////////////////////////////////////////
  // operands, alu, branch
  ////////////////////////////////////////

  function automatic cpu_pkg::data_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                             input cpu_pkg::data_t reg_val);
    case (sel)
      cpu_pkg::FWD_EX_MEM: return ex_mem_alu_result;
      cpu_pkg::FWD_MEM_WB: return mem_wb_data;
      default:             return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a      = fwd_mux(fwd_a, id_ex_data_1);
    fwd_val_b = fwd_mux(fwd_b, id_ex_data_2);
    op_b      = id_ex_alu_src ? cpu_pkg::data_t'(id_ex_field) : fwd_val_b;
    case (id_ex_alu_op)
      cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
      cpu_pkg::ALU_AND: alu_result = op_a & op_b;
      cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
      // signed compare
      cpu_pkg::ALU_SLT: alu_result = cpu_pkg::data_t'($signed(op_a) < $signed(op_b));
      default:          alu_result = op_a + op_b;
    endcase
  end

  assign branch_taken  = (id_ex_beq && (op_a == fwd_val_b)) ||
                         (id_ex_bne && (op_a != fwd_val_b));
  assign branch_target = id_ex_field;
  // r-type writes rd, the rest rt
  assign dst           = id_ex_reg_dst ? id_ex_rd : id_ex_rt;

  ////////////////////////////////////////
  // ex/mem
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      {ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_halt} <= '0;
    end else begin
      ex_mem_reg_write <= id_ex_reg_write;
      ex_mem_mem_read  <= id_ex_is_load;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_halt      <= id_ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_alu_result <= alu_result;
    ex_mem_store_data <= fwd_val_b;
    ex_mem_dst        <= dst;
  end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`default_nettype none

module register_file (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     we,
  input  wire cpu_pkg::reg_addr_t waddr,
  input  wire cpu_pkg::data_t     wdata,
  input  wire cpu_pkg::reg_addr_t raddr_1,
  input  wire cpu_pkg::reg_addr_t raddr_2,
  output cpu_pkg::data_t          rdata_1,
  output cpu_pkg::data_t          rdata_2
);

  cpu_pkg::data_t regs [8];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // same-cycle write shows through to decode
  function automatic cpu_pkg::data_t read_port(input cpu_pkg::reg_addr_t raddr);
    if (raddr == '0) return '0;
    if (we && (waddr == raddr)) return wdata;
    return regs[raddr];
  endfunction

  always_comb begin
    rdata_1 = read_port(raddr_1);
    rdata_2 = read_port(raddr_2);
  end

endmodule

`default_nettype wire

// File: hw/control_unit.sv
`default_nettype none

module control_unit (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire cpu_pkg::inst_t     if_id_inst,
  input  wire cpu_pkg::reg_addr_t id_ex_rt,
  input  wire                     id_ex_is_load,
  input  wire cpu_pkg::reg_addr_t ex_mem_dst,
  input  wire                     ex_mem_reg_write,
  input  wire cpu_pkg::reg_addr_t mem_wb_dst,
  input  wire                     mem_wb_reg_write,
  input  wire                     branch_taken,
  output cpu_pkg::alu_op_t        alu_op,
  output logic                    alu_src,
  output logic                    reg_dst,
  output logic                    reg_write,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    is_beq,
  output logic                    is_bne,
  output logic                    is_halt,
  output cpu_pkg::fwd_sel_t       fwd_a,
  output cpu_pkg::fwd_sel_t       fwd_b,
  output logic                    stall,
  output logic                    flush
);

  cpu_pkg::op_t       op;
  cpu_pkg::reg_addr_t if_rs;
  cpu_pkg::reg_addr_t if_rt;
  // rs of the instruction now in execute
  cpu_pkg::reg_addr_t id_ex_rs;

  assign op    = cpu_pkg::op_t'(if_id_inst[15:12]);
  assign if_rs = if_id_inst[11:9];
  assign if_rt = if_id_inst[8:6];

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  always_comb begin
    alu_op    = cpu_pkg::ALU_ADD;
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_beq    = 1'b0;
    is_bne    = 1'b0;
    is_halt   = 1'b0;
    case (op)
      cpu_pkg::OP_ADD:  {reg_dst, reg_write} = 2'b11;
      cpu_pkg::OP_SUB: begin
        alu_op               = cpu_pkg::ALU_SUB;
        {reg_dst, reg_write} = 2'b11;
      end
      cpu_pkg::OP_AND: begin
        alu_op               = cpu_pkg::ALU_AND;
        {reg_dst, reg_write} = 2'b11;
      end
      cpu_pkg::OP_OR: begin
        alu_op               = cpu_pkg::ALU_OR;
        {reg_dst, reg_write} = 2'b11;
      end
      cpu_pkg::OP_SLT: begin
        alu_op               = cpu_pkg::ALU_SLT;
        {reg_dst, reg_write} = 2'b11;
      end
      cpu_pkg::OP_ADDI: {alu_src, reg_write} = 2'b11;
      cpu_pkg::OP_LW:   {alu_src, reg_write, mem_read} = 3'b111;
      cpu_pkg::OP_SW:   {alu_src, mem_write} = 2'b11;
      cpu_pkg::OP_BEQ:  is_beq = 1'b1;
      cpu_pkg::OP_BNE:  is_bne = 1'b1;
      cpu_pkg::OP_HALT: is_halt = 1'b1;
      // jmp is consumed in fetch, nop and spare codes do nothing
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // hazards
  ////////////////////////////////////////

  // load result not ready for the next instruction
  assign stall = id_ex_is_load && (id_ex_rt != '0) &&
                 ((id_ex_rt == if_rs) || (id_ex_rt == if_rt));
  assign flush = branch_taken;

  // follows id/ex, bubbles carry r0
  always_ff @(posedge clk) begin
    if (!rst_n || stall || flush) begin
      id_ex_rs <= '0;
    end else begin
      id_ex_rs <= if_rs;
    end
  end

  // newest producer wins
  function automatic cpu_pkg::fwd_sel_t pick_fwd(input cpu_pkg::reg_addr_t src);
    if (src == '0) return cpu_pkg::FWD_REG;
    if (ex_mem_reg_write && (ex_mem_dst == src)) return cpu_pkg::FWD_EX_MEM;
    if (mem_wb_reg_write && (mem_wb_dst == src)) return cpu_pkg::FWD_MEM_WB;
    return cpu_pkg::FWD_REG;
  endfunction

  always_comb begin
    fwd_a = pick_fwd(id_ex_rs);
    fwd_b = pick_fwd(id_ex_rt);
  end

  a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !stall);

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`default_nettype none

module fetch_stage #(
  parameter int IMEM_DEPTH = 64
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 run,
  input  wire                 load_req,
  input  wire cpu_pkg::pc_t   load_addr,
  input  wire cpu_pkg::inst_t load_data,
  input  wire                 stall,
  input  wire                 flush,
  input  wire cpu_pkg::pc_t   branch_target,
  output logic                load_ack,
  output cpu_pkg::inst_t      if_id_inst
);

  cpu_pkg::inst_t imem [IMEM_DEPTH];
  cpu_pkg::pc_t   pc;
  cpu_pkg::inst_t fetch_inst;
  cpu_pkg::op_t   fetch_op;
  // run as sampled on the last edge
  logic           running;

  assign fetch_inst = imem[pc];
  assign fetch_op   = cpu_pkg::op_t'(fetch_inst[15:12]);

  ////////////////////////////////////////
  // program load, four-phase req/ack
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_ack <= 1'b0;
    end else if (!load_req) begin
      load_ack <= 1'b0;
    end else if (!run) begin
      load_ack <= 1'b1;
    end
  end

  // one write per request, before ack goes up
  always_ff @(posedge clk) begin
    if (load_req && !load_ack && !run) begin
      imem[load_addr] <= load_data;
    end
  end

  ////////////////////////////////////////
  // pc and if/id
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running    <= 1'b0;
      pc         <= '0;
      if_id_inst <= cpu_pkg::INST_NOP;
    end else begin
      running <= run;
      if (!running) begin
        pc         <= '0;
        if_id_inst <= cpu_pkg::INST_NOP;
      end else if (flush) begin
        // taken branch in execute
        pc         <= branch_target;
        if_id_inst <= cpu_pkg::INST_NOP;
      end else if (!stall) begin
        case (fetch_op)
          cpu_pkg::OP_JMP: begin
            pc         <= fetch_inst[5:0];
            if_id_inst <= cpu_pkg::INST_NOP;
          end
          // pc parks on the halt
          cpu_pkg::OP_HALT: if_id_inst <= fetch_inst;
          default: begin
            pc         <= pc + cpu_pkg::pc_t'(1);
            if_id_inst <= fetch_inst;
          end
        endcase
      end
    end
  end

  a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
    run |-> !load_req);

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // register or memory word
  typedef logic [15:0] data_t;
  // instruction word
  typedef logic [15:0] inst_t;
  // register number, r0 reads as zero
  typedef logic [2:0]  reg_addr_t;
  // word address for both memories, set by the 6-bit field
  typedef logic [5:0]  pc_t;

  // all-zero word decodes as a bubble
  localparam inst_t INST_NOP = 16'h0000;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // opcode in bits 15:12
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_SLT  = 4'd5,
    OP_ADDI = 4'd6,
    OP_LW   = 4'd7,
    OP_SW   = 4'd8,
    OP_BEQ  = 4'd9,
    OP_BNE  = 4'd10,
    OP_JMP  = 4'd11,
    OP_HALT = 4'd12
  } op_t;

  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

  // operand source in execute
  typedef enum logic [1:0] {FWD_REG, FWD_MEM_WB, FWD_EX_MEM} fwd_sel_t;

endpackage

`default_nettype wire
